// ==== source/datapath_cfg.svh ====
// widths and depths for the bus datapath; register index and immediate widths must fit a 32-bit word
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

`define DATA_WIDTH 32     // bus and register width
`define REG_COUNT 16      // R0 always reads zero
`define REG_IDX_WIDTH 4   // log2 of REG_COUNT
`define OPCODE_WIDTH 5
`define IMM_WIDTH 19      // I-format immediate field

// queue depth, equal to the sender's starting credits
`define INSTR_CREDITS 4

`endif

// ==== source/isaPkg.sv ====
// instruction set types; any opcode value outside the enum is treated as illegal by the decoder
`include "datapath_cfg.svh"

package isaPkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        SHL  = 5'd5,
        SHR  = 5'd6,  // logical
        ADDI = 5'd7,  // immediate is sign-extended
        ORI  = 5'd8   // immediate is zero-extended
    } opcodeT;

    // register-register format
    typedef struct packed {
        opcodeT                    op;
        logic [`REG_IDX_WIDTH-1:0] ra;      // destination
        logic [`REG_IDX_WIDTH-1:0] rb;
        logic [`REG_IDX_WIDTH-1:0] rc;
        logic [14:0]               unused;
    } rFormatT;

    // register-immediate format
    typedef struct packed {
        opcodeT                    op;
        logic [`REG_IDX_WIDTH-1:0] ra;
        logic [`REG_IDX_WIDTH-1:0] rb;
        logic [`IMM_WIDTH-1:0]     imm;
    } iFormatT;

    // one 32-bit word, read as either format
    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

endpackage

// ==== source/datapathPkg.sv ====
// datapath control and port types; instruction encodings come from isaPkg, which compiles first
`include "datapath_cfg.svh"

package datapathPkg;

    // owner of the shared internal bus
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        REGFILE   = 2'd1,
        IMMEDIATE = 2'd2,
        ALURESULT = 2'd3
    } busSourceT;

    // one control step, as issued by the sequencer each cycle
    typedef struct packed {
        busSourceT                 busSource;
        logic [`REG_IDX_WIDTH-1:0] regSelect;  // read and write index
        logic                      regWrite;
        logic                      yLoad;
        logic                      zLoad;
        isaPkg::opcodeT            aluOp;
        logic                      immSigned;  // sign-extend the immediate when set
    } ctrlT;

    // credit-based instruction port, no ready
    typedef struct packed {
        logic          valid;
        isaPkg::instrT instr;
    } instrInT;

    // retirement report, one cycle per instruction
    typedef struct packed {
        logic                      valid;
        logic                      illegal;
        logic [`REG_IDX_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]    value;
    } writebackT;

endpackage

// ==== source/instrQueue.sv ====
// instruction FIFO; the sender must hold a credit per push, so a push into a full queue is not checked
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module instrQueue (
    input  logic                 Clock,
    input  logic                 rstN,
    input  datapathPkg::instrInT instrIn,
    input  logic                 pop,
    output isaPkg::instrT        head,
    output logic                 notEmpty,
    output logic                 creditReturn
);

    localparam int DEPTH = `INSTR_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);

    isaPkg::instrT    entries [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;  // one extra bit to hold DEPTH
    logic             doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign doPop    = pop && notEmpty;
    assign head     = entries[rdPtr];

    always_ff @(posedge Clock) begin
        if (instrIn.valid) entries[wrPtr] <= instrIn.instr;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (instrIn.valid) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            case ({instrIn.valid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // push and pop together, or idle
            endcase
            creditReturn <= doPop;  // one credit back per popped entry
        end
    end

endmodule

// ==== source/controlSequencer.sv ====
// four-step sequencer, one instruction every 4 cycles; unknown opcodes retire flagged with no write
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module controlSequencer (
    input  logic                   Clock,
    input  logic                   rstN,
    input  isaPkg::instrT          head,
    input  logic                   notEmpty,
    input  logic [`DATA_WIDTH-1:0] zValue,
    output logic                   pop,
    output datapathPkg::ctrlT      ctrl,
    output logic [`IMM_WIDTH-1:0]  immField,
    output datapathPkg::writebackT writeback
);

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        OPERANDA  = 2'd1,
        OPERANDB  = 2'd2,
        WRITEBACK = 2'd3
    } stepT;

    stepT          step;
    isaPkg::instrT instrReg;
    logic          isImm;
    logic          illegal;

    // R and I formats share the op field, so read it through either view
    always_comb begin
        isImm   = 1'b0;
        illegal = 1'b0;
        case (instrReg.r.op)
            isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR,
            isaPkg::XOR, isaPkg::SHL, isaPkg::SHR: isImm = 1'b0;
            isaPkg::ADDI, isaPkg::ORI:             isImm = 1'b1;
            default:                               illegal = 1'b1;
        endcase
    end

    assign pop      = (step == FETCH) && notEmpty;
    assign immField = instrReg.i.imm;

    // control word for the current step
    always_comb begin
        ctrl = '0;  // bus idle, no loads
        case (step)
            OPERANDA: begin
                ctrl.busSource = datapathPkg::REGFILE;
                ctrl.regSelect = instrReg.r.rb;
                ctrl.yLoad     = 1'b1;
            end
            OPERANDB: begin
                if (isImm) begin
                    ctrl.busSource = datapathPkg::IMMEDIATE;
                    ctrl.immSigned = (instrReg.i.op == isaPkg::ADDI);
                end else begin
                    ctrl.busSource = datapathPkg::REGFILE;
                    ctrl.regSelect = instrReg.r.rc;
                end
                ctrl.zLoad = 1'b1;
                ctrl.aluOp = instrReg.r.op;
            end
            WRITEBACK: begin
                ctrl.busSource = datapathPkg::ALURESULT;
                ctrl.regSelect = instrReg.r.ra;
                ctrl.regWrite  = !illegal;
            end
            default: ;  // FETCH leaves the bus to nobody
        endcase
    end

    always_ff @(posedge Clock) begin
        if (pop) instrReg <= head;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            step      <= FETCH;
            writeback <= '0;
        end else begin
            case (step)
                FETCH:     if (notEmpty) step <= OPERANDA;  // wait here for work
                OPERANDA:  step <= OPERANDB;
                OPERANDB:  step <= WRITEBACK;
                WRITEBACK: step <= FETCH;
                default:   step <= FETCH;
            endcase
            // report goes out the cycle after WRITEBACK
            writeback.valid <= (step == WRITEBACK);
            if (step == WRITEBACK) begin
                writeback.illegal <= illegal;
                writeback.dest    <= instrReg.r.ra;
                writeback.value   <= zValue;
            end
        end
    end

endmodule

// ==== source/busArbiter.sv ====
// shared bus mux, one owner per cycle as named by the control step; an unowned bus reads zero
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module busArbiter (
    input  datapathPkg::ctrlT      ctrl,
    input  logic [`DATA_WIDTH-1:0] regData,
    input  logic [`IMM_WIDTH-1:0]  immField,
    input  logic [`DATA_WIDTH-1:0] zValue,
    output logic [`DATA_WIDTH-1:0] busWord
);

    localparam int EXT_W = `DATA_WIDTH - `IMM_WIDTH;

    logic [`DATA_WIDTH-1:0] immExt;

    // ADDI wants the sign, ORI wants zeros
    assign immExt = ctrl.immSigned ? {{EXT_W{immField[`IMM_WIDTH-1]}}, immField}
                                   : {{EXT_W{1'b0}}, immField};

    always_comb begin
        case (ctrl.busSource)
            datapathPkg::REGFILE:   busWord = regData;
            datapathPkg::IMMEDIATE: busWord = immExt;
            datapathPkg::ALURESULT: busWord = zValue;
            default:                busWord = '0;  // NONE
        endcase
    end

endmodule

// ==== source/registerFile.sv ====
// register file with one asynchronous read and one bus-fed write; R0 is hardwired to zero
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   rstN,
    input  datapathPkg::ctrlT      ctrl,
    input  logic [`DATA_WIDTH-1:0] busWord,
    output logic [`DATA_WIDTH-1:0] regData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   selZero;

    assign selZero = (ctrl.regSelect == '0);

    // read port, R0 forced low whatever the array holds
    assign regData = selZero ? '0 : regs[ctrl.regSelect];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && !selZero) begin
            regs[ctrl.regSelect] <= busWord;  // writes to R0 are dropped
        end
    end

endmodule

// ==== source/aluUnit.sv ====
// Y operand and Z result registers around the ALU; shifts use bits 4:0 of the bus operand only
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module aluUnit (
    input  logic                   Clock,
    input  logic                   rstN,
    input  datapathPkg::ctrlT      ctrl,
    input  logic [`DATA_WIDTH-1:0] busWord,
    output logic [`DATA_WIDTH-1:0] zValue
);

    logic [`DATA_WIDTH-1:0] yReg;
    logic [`DATA_WIDTH-1:0] zReg;
    logic [`DATA_WIDTH-1:0] result;
    logic [4:0]             shamt;

    assign shamt  = busWord[4:0];
    assign zValue = zReg;

    // Y is the first operand, the bus the second
    always_comb begin
        case (ctrl.aluOp)
            isaPkg::ADD:  result = yReg + busWord;
            isaPkg::SUB:  result = yReg - busWord;
            isaPkg::AND:  result = yReg & busWord;
            isaPkg::OR:   result = yReg | busWord;
            isaPkg::XOR:  result = yReg ^ busWord;
            isaPkg::SHL:  result = yReg << shamt;
            isaPkg::SHR:  result = yReg >> shamt;  // zero fill
            isaPkg::ADDI: result = yReg + busWord;
            isaPkg::ORI:  result = yReg | busWord;
            default:      result = '0;  // illegal op leaves a zero result
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (ctrl.yLoad) yReg <= busWord;
            if (ctrl.zLoad) zReg <= result;
        end
    end

endmodule

// ==== source/dataPath.sv ====
// datapath top; the sender must follow the credit rule, and the writeback port cannot stall
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module dataPath (
    input  logic                   Clock,
    input  logic                   rstN,
    input  datapathPkg::instrInT   instrIn,
    output logic                   creditReturn,
    output datapathPkg::writebackT writeback
);

    isaPkg::instrT          queueHead;
    logic                   queueNotEmpty;
    logic                   pop;
    datapathPkg::ctrlT      ctrl;      // fanned out to arbiter and peers
    logic [`IMM_WIDTH-1:0]  immField;
    logic [`DATA_WIDTH-1:0] regData;
    logic [`DATA_WIDTH-1:0] zValue;
    logic [`DATA_WIDTH-1:0] busWord;   // the shared internal bus

    instrQueue i_instrQueue (
        .Clock        (Clock),
        .rstN         (rstN),
        .instrIn      (instrIn),
        .pop          (pop),
        .head         (queueHead),
        .notEmpty     (queueNotEmpty),
        .creditReturn (creditReturn)
    );

    controlSequencer i_controlSequencer (
        .Clock     (Clock),
        .rstN      (rstN),
        .head      (queueHead),
        .notEmpty  (queueNotEmpty),
        .zValue    (zValue),
        .pop       (pop),
        .ctrl      (ctrl),
        .immField  (immField),
        .writeback (writeback)
    );

    busArbiter i_busArbiter (
        .ctrl     (ctrl),
        .regData  (regData),
        .immField (immField),
        .zValue   (zValue),
        .busWord  (busWord)
    );

    registerFile i_registerFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busWord (busWord),
        .regData (regData)
    );

    aluUnit i_aluUnit (
        .Clock   (Clock),
        .rstN    (rstN),
        .ctrl    (ctrl),
        .busWord (busWord),
        .zValue  (zValue)
    );

endmodule

// ==== testbench/clockGen.sv ====
// free-running testbench clock with a power-on reset; reset releases 1 ns after a rising edge
`timescale 1ns/1ns

module clockGen #(
    parameter int HALF_PERIOD  = 2,  // 4 ns period
    parameter int RESET_CYCLES = 3
) (
    output logic Clock,
    output logic rstN
);

    initial begin
        Clock = 1'b0;
        forever #HALF_PERIOD Clock = ~Clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clock);
        #1 rstN = 1'b1;  // lines up with the stimulus offset
    end

endmodule

// ==== testbench/dataPathTb.sv ====
// self-checking testbench; expects in-order retirement and a zero report value for illegal opcodes
`timescale 1ns/1ns
`include "datapath_cfg.svh"

module dataPathTb;

    localparam int WAIT_LIMIT  = 400;  // cycles allowed per wait loop
    localparam int LATENCY     = 5;    // send cycle to report cycle on an idle DUT
    localparam int RANDOM_RUNS = 300;

    logic                   Clock;
    logic                   rstN;
    datapathPkg::instrInT   instrIn;
    logic                   creditReturn;
    datapathPkg::writebackT writeback;

    datapathPkg::writebackT expQ [$];  // expected reports in send order
    datapathPkg::writebackT lastWb;
    logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
    logic [31:0]            lfsrState = 32'h88d61f6c;
    int                     credits = `INSTR_CREDITS;
    int                     creditPulses = 0;
    int                     sentCount = 0;
    int                     wbCount = 0;
    int                     cycleCount = 0;
    int                     lastWbCycle = 0;
    int                     lastCreditCycle = 0;

    clockGen i_clockGen (
        .Clock (Clock),
        .rstN  (rstN)
    );

    dataPath i_dataPath (
        .Clock        (Clock),
        .rstN         (rstN),
        .instrIn      (instrIn),
        .creditReturn (creditReturn),
        .writeback    (writeback)
    );

    always @(posedge Clock) cycleCount <= cycleCount + 1;

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "testbench stopped at %0t", $time);
    endtask

    function automatic string wbText(input datapathPkg::writebackT wb);
        return $sformatf("{valid %b illegal %b dest R%0d value %h}",
                         wb.valid, wb.illegal, wb.dest, wb.value);
    endfunction

    task automatic checkWriteback(input datapathPkg::writebackT actual,
                                  input datapathPkg::writebackT expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: writeback expected %s, got %s",
                     $time, wbText(expected), wbText(actual));
            stopOnError("writeback report is wrong");
        end
    endtask

    // one call per sampled cycle, keeps the sender's credit count
    task automatic checkCredit(input logic pulse);
        if (pulse) begin
            credits++;
            creditPulses++;
            lastCreditCycle = cycleCount;
        end
        if (credits > `INSTR_CREDITS) begin
            stopOnError($sformatf("credit counter went above the queue depth at %0t: %0d",
                                  $time, credits));
        end
    endtask

    task automatic compareCount(input int actual, input int expected, input string name);
        if (actual != expected) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            stopOnError("count check is wrong");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            lfsrState = nextLfsr(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic isaPkg::instrT makeR(input logic [4:0] op, input logic [3:0] ra,
                                            input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic isaPkg::instrT makeI(input logic [4:0] op, input logic [3:0] ra,
                                            input logic [3:0] rb, input logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic datapathPkg::writebackT makeWb(input logic [3:0] dest,
                                                      input logic [31:0] value);
        datapathPkg::writebackT wb;
        wb.valid   = 1'b1;
        wb.illegal = 1'b0;
        wb.dest    = dest;
        wb.value   = value;
        return wb;
    endfunction

    function automatic isaPkg::instrT randomInstr();
        logic [4:0]  raw;
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] low;
        raw = 5'(takeBits(5));
        op  = (raw < 5'd27) ? 5'(raw % 5'd9) : raw;  // 27..31 stay illegal
        ra  = 4'(takeBits(4));
        rb  = 4'(takeBits(4));
        low = 19'(takeBits(19));  // rc field or immediate
        return {op, ra, rb, low};
    endfunction

    // expected report for one instruction, also updates the model registers
    function automatic datapathPkg::writebackT refModel(input isaPkg::instrT instr);
        datapathPkg::writebackT wb;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            immS;
        logic [31:0]            immZ;
        a    = modelRegs[instr.r.rb];
        b    = modelRegs[instr.r.rc];
        immS = {{(`DATA_WIDTH - `IMM_WIDTH){instr.i.imm[`IMM_WIDTH-1]}}, instr.i.imm};
        immZ = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, instr.i.imm};
        wb   = makeWb(instr.r.ra, 32'd0);
        case (instr.r.op)
            isaPkg::ADD:  wb.value = a + b;
            isaPkg::SUB:  wb.value = a - b;
            isaPkg::AND:  wb.value = a & b;
            isaPkg::OR:   wb.value = a | b;
            isaPkg::XOR:  wb.value = a ^ b;
            isaPkg::SHL:  wb.value = a << b[4:0];
            isaPkg::SHR:  wb.value = a >> b[4:0];
            isaPkg::ADDI: wb.value = a + immS;
            isaPkg::ORI:  wb.value = a | immZ;
            default:      wb.illegal = 1'b1;  // value stays zero
        endcase
        if (!wb.illegal && wb.dest != 4'd0) modelRegs[wb.dest] = wb.value;
        return wb;
    endfunction

    // entered and left 1 ns after a rising edge
    task automatic sendInstr(input isaPkg::instrT instr);
        int waited;
        waited = 0;
        while (credits == 0) begin
            @(posedge Clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stopOnError("timed out waiting for an instruction credit");
        end
        expQ.push_back(refModel(instr));
        instrIn.valid = 1'b1;
        instrIn.instr = instr;
        credits--;
        sentCount++;
        @(posedge Clock);
        #1;
        instrIn.valid = 1'b0;
    endtask

    // each credit comes back before its report, so all are due once the reports are in
    task automatic waitIdle();
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            @(posedge Clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stopOnError("timed out waiting for the datapath to drain");
        end
        compareCount(creditPulses, sentCount, "creditReturn pulses");
    endtask

    // compare process, outputs sampled mid-cycle
    always @(negedge Clock) begin
        if (rstN === 1'b1) begin
            checkCredit(creditReturn);
            if (writeback.valid === 1'b1) begin
                if (expQ.size() == 0) begin
                    stopOnError("writeback report arrived with nothing outstanding");
                end else begin
                    checkWriteback(writeback, expQ.pop_front());
                    lastWb      = writeback;
                    lastWbCycle = cycleCount;
                    wbCount++;
                end
            end
        end
    end

    initial begin
        int waited;
        int startWb;
        int sendCycle;
        int gap;
        instrIn = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        waited = 0;
        while (rstN !== 1'b1) begin
            @(posedge Clock);
            waited++;
            if (waited > WAIT_LIMIT) stopOnError("reset was never released");
        end
        @(posedge Clock);
        #1;
        if (writeback.valid !== 1'b0 || creditReturn !== 1'b0) begin
            stopOnError("writeback or creditReturn active right after reset");
        end

        // immediate loads and their extension
        sendInstr(makeI(isaPkg::ADDI, 4'd1, 4'd0, 19'd24));
        waitIdle();
        checkWriteback(lastWb, makeWb(4'd1, 32'd24));
        sendInstr(makeI(isaPkg::ORI, 4'd2, 4'd0, 19'h0ffff));
        waitIdle();
        checkWriteback(lastWb, makeWb(4'd2, 32'h0000_ffff));
        sendInstr(makeI(isaPkg::ADDI, 4'd3, 4'd0, 19'h7fffe));  // -2
        waitIdle();
        checkWriteback(lastWb, makeWb(4'd3, 32'hffff_fffe));

        // register ops reading earlier results
        sendInstr(makeR(isaPkg::OR, 4'd1, 4'd2, 4'd3));
        sendInstr(makeR(isaPkg::ADD, 4'd4, 4'd1, 4'd2));
        sendInstr(makeR(isaPkg::SUB, 4'd5, 4'd2, 4'd3));
        sendInstr(makeR(isaPkg::AND, 4'd6, 4'd1, 4'd3));
        sendInstr(makeR(isaPkg::XOR, 4'd7, 4'd2, 4'd3));
        sendInstr(makeR(isaPkg::SHL, 4'd8, 4'd2, 4'd3));
        sendInstr(makeR(isaPkg::SHR, 4'd9, 4'd1, 4'd2));
        waitIdle();

        // single instruction latency on an idle DUT
        startWb   = wbCount;
        sendCycle = cycleCount;
        sendInstr(makeR(isaPkg::ADD, 4'd10, 4'd4, 4'd5));
        waited = 0;
        while (wbCount == startWb) begin
            @(posedge Clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stopOnError("timed out waiting for the single report");
        end
        compareCount(lastWbCycle - sendCycle, LATENCY, "writeback latency");
        if (lastCreditCycle <= sendCycle || lastCreditCycle >= lastWbCycle) begin
            stopOnError("creditReturn did not come between the send and the report");
        end
        waitIdle();

        // bursts that use up all credits
        for (int burst = 0; burst < 3; burst++) begin
            for (int j = 0; j < 2 * `INSTR_CREDITS; j++) begin
                sendInstr(randomInstr());
            end
            waitIdle();
        end

        // R0 write and an illegal opcode
        sendInstr(makeR(isaPkg::ADD, 4'd0, 4'd1, 4'd2));
        sendInstr(makeR(isaPkg::OR, 4'd11, 4'd0, 4'd0));
        sendInstr(makeR(5'd20, 4'd4, 4'd1, 4'd2));
        sendInstr(makeR(isaPkg::XOR, 4'd12, 4'd4, 4'd0));
        sendInstr(makeI(isaPkg::ORI, 4'd13, 4'd0, 19'd0));
        waitIdle();

        // random mix with random gaps
        for (int n = 0; n < RANDOM_RUNS; n++) begin
            sendInstr(randomInstr());
            gap = int'(takeBits(2));
            for (int g = 0; g < gap; g++) begin
                @(posedge Clock);
                #1;
            end
        end
        waitIdle();

        $display("sim passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/isaPkg.sv
source/datapathPkg.sv
source/instrQueue.sv
source/controlSequencer.sv
source/busArbiter.sv
source/registerFile.sv
source/aluUnit.sv
source/dataPath.sv
testbench/clockGen.sv
testbench/dataPathTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the datapath testbench with Verilator, runs it and scans the log for the fail line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module dataPathTb -f sim.f -o dataPathSim

# the exit status of tee is kept, so the log search below makes the decision
./obj_dir/dataPathSim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "run.sh: testbench reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "run.sh: testbench ended without a pass line, see sim.log"
    exit 1
fi
echo "run.sh: done"
